/* rtl/adc_capture_params.svh */
`ifndef ADC_CAPTURE_PARAMS_SVH
`define ADC_CAPTURE_PARAMS_SVH

// bits per ADC conversion
`define ADC_SAMPLE_W 12

// three samples per FIFO word
`define ADC_WORD_W 36

`define ADC_SAMPLES_PER_WORD 3

// default word depth of the capture FIFO
`define ADC_FIFO_DEPTH 64

// sample count and thinning ratio inputs
`define ADC_COUNT_W 16

`endif

/* rtl/capture_pkg.sv */
`default_nettype none

`include "adc_capture_params.svh"

package capture_pkg;

    typedef logic [`ADC_SAMPLE_W-1:0] sample_t;    // one raw conversion
    typedef logic [`ADC_COUNT_W-1:0]  count_t;     // sample count or thinning ratio

    // one kept sample, valid for a single cycle
    typedef struct packed {
        logic    valid;
        sample_t sample;
    } sample_beat_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ARMED,
        ST_CAPTURING,
        ST_DONE
    } capture_state_e;

    typedef struct packed {
        logic clip;
        logic overflow;
        logic underflow;
    } error_status_t;

endpackage

`default_nettype wire

/* rtl/readout_pkg.sv */
`default_nettype none

`include "adc_capture_params.svh"

package readout_pkg;

    // oldest sample sits in the top bits
    typedef logic [`ADC_WORD_W-1:0] word_t;

    typedef logic [7:0] byte_t;         // one byte toward the host

    typedef struct packed {
        logic  wr;                       // one-cycle write strobe
        word_t data;
    } word_write_t;

    // position in a read cycle: 0-2 low res, 0-8 full res
    typedef logic [3:0] byte_slot_t;

endpackage

`default_nettype wire

/* rtl/capture_control.sv */
`default_nettype none

`include "adc_capture_params.svh"

module capture_control (
    input  wire logic                    adc_sampleclk,
    input  wire logic                    fifo_rst,
    input  wire logic                    arm_i,
    input  wire logic                    capture_go_i,
    input  wire capture_pkg::sample_t    adc_data_i,
    input  wire capture_pkg::count_t     downsample_i,
    input  wire capture_pkg::count_t     max_samples_i,
    output capture_pkg::sample_beat_t    beat_o,
    output logic                         clip_o,
    output logic                         capture_stop_o
);

    import capture_pkg::*;

    capture_state_e        state;
    logic                  arm_r;
    logic                  go_r;
    logic                  arm_rise;
    logic                  go_rise;
    count_t                thin_cnt;
    logic [`ADC_COUNT_W:0] kept_cnt;        // one extra bit for round-up past max
    logic [1:0]            kept_phase;      // kept samples mod three
    logic                  take;
    logic                  last_take;
    logic                  beat_valid;
    sample_t               beat_sample;

    assign arm_rise = arm_i & ~arm_r;
    assign go_rise  = capture_go_i & ~go_r;

    // keep one sample in every downsample_i + 1
    assign take = (state == ST_CAPTURING) && (thin_cnt >= downsample_i);

    // target reached and word boundary reached together
    assign last_take = take && (kept_phase == 2'd2) &&
                       ((kept_cnt + 1'b1) >= {1'b0, max_samples_i});

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst) begin
            state          <= ST_IDLE;
            arm_r          <= 1'b0;
            go_r           <= 1'b0;
            thin_cnt       <= '0;
            kept_cnt       <= '0;
            kept_phase     <= '0;
            capture_stop_o <= 1'b0;
        end else begin
            arm_r <= arm_i;
            go_r  <= capture_go_i;
            case (state)
                ST_IDLE, ST_DONE: begin
                    if (arm_rise) begin
                        state          <= ST_ARMED;
                        thin_cnt       <= '0;
                        kept_cnt       <= '0;
                        kept_phase     <= '0;
                        capture_stop_o <= 1'b0;
                    end else if (state == ST_DONE) begin
                        capture_stop_o <= 1'b1;    // one cycle after the last beat
                    end
                end
                ST_ARMED: begin
                    if (go_rise) begin
                        state <= ST_CAPTURING;
                    end
                end
                ST_CAPTURING: begin
                    if (take) begin
                        thin_cnt   <= '0;
                        kept_cnt   <= kept_cnt + 1'b1;
                        kept_phase <= (kept_phase == 2'd2) ? 2'd0 : kept_phase + 2'd1;
                        if (last_take) begin
                            state <= ST_DONE;
                        end
                    end else begin
                        thin_cnt <= thin_cnt + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst) begin
            beat_valid <= 1'b0;
            clip_o     <= 1'b0;
        end else begin
            beat_valid <= take;
            clip_o     <= take && ((adc_data_i == '0) || (adc_data_i == '1));    // rail hit
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (take) begin
            beat_sample <= adc_data_i;
        end
    end

    assign beat_o = '{valid: beat_valid, sample: beat_sample};

    // the last beat of a capture comes out before the stop level
    a_beat_in_capture: assert property (
        @(posedge adc_sampleclk) disable iff (fifo_rst)
        beat_valid |-> (state == ST_CAPTURING) || ((state == ST_DONE) && !capture_stop_o)
    );

endmodule

`default_nettype wire

/* rtl/sample_packer.sv */
`default_nettype none

`include "adc_capture_params.svh"

module sample_packer (
    input  wire logic                      adc_sampleclk,
    input  wire logic                      fifo_rst,
    input  wire capture_pkg::sample_beat_t beat_i,
    output readout_pkg::word_write_t       wr_o
);

    import readout_pkg::*;

    logic [1:0] phase;     // samples already in the word
    logic       wr;
    word_t      shift_r;

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst) begin
            phase <= '0;
            wr    <= 1'b0;
        end else begin
            wr <= 1'b0;
            if (beat_i.valid) begin
                if (phase == 2'(`ADC_SAMPLES_PER_WORD - 1)) begin
                    phase <= '0;
                    wr    <= 1'b1;    // word complete
                end else begin
                    phase <= phase + 2'd1;
                end
            end
        end
    end

    // newest sample enters at the bottom, so the oldest ends up highest
    always_ff @(posedge adc_sampleclk) begin
        if (beat_i.valid) begin
            shift_r <= {shift_r[`ADC_WORD_W-`ADC_SAMPLE_W-1:0], beat_i.sample};
        end
    end

    assign wr_o = '{wr: wr, data: shift_r};

    // three beats at least between two words
    a_no_back_to_back_wr: assert property (
        @(posedge adc_sampleclk) disable iff (fifo_rst)
        wr |=> !wr
    );

endmodule

`default_nettype wire

/* rtl/word_fifo.sv */
`default_nettype none

`include "adc_capture_params.svh"

module word_fifo #(
    parameter int DEPTH = `ADC_FIFO_DEPTH
) (
    input  wire logic                     adc_sampleclk,
    input  wire logic                     fifo_rst,
    input  wire readout_pkg::word_write_t wr_i,
    input  wire logic                     pop_i,
    output readout_pkg::word_t            head_o,
    output logic                          empty_o,
    output logic                          overflow_o,
    output logic                          underflow_o
);

    import readout_pkg::*;

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    word_t         mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;      // occupancy, 0 to DEPTH
    logic          full;
    logic          do_wr;
    logic          do_pop;

    assign full    = (count == (AW+1)'(DEPTH));
    assign empty_o = (count == '0);
    assign do_wr   = wr_i.wr && !full;
    assign do_pop  = pop_i && !empty_o;

    assign overflow_o  = wr_i.wr && full;     // word is lost
    assign underflow_o = pop_i && empty_o;    // pop ignored

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_i.data;
        end
    end

    assign head_o = mem[rd_ptr];    // show-ahead

    a_count_in_range: assert property (
        @(posedge adc_sampleclk) disable iff (fifo_rst)
        count <= (AW+1)'(DEPTH)
    );

endmodule

`default_nettype wire

/* rtl/byte_reader.sv */
`default_nettype none

module byte_reader (
    input  wire logic                 adc_sampleclk,
    input  wire logic                 fifo_rst,
    input  wire logic                 fifo_read_en_i,
    input  wire logic                 low_res_i,
    input  wire logic                 clear_errors_i,
    input  wire readout_pkg::word_t   head_i,
    input  wire logic                 empty_i,
    input  wire logic                 clip_i,
    input  wire logic                 overflow_i,
    input  wire logic                 underflow_i,
    output logic                      pop_o,
    output readout_pkg::byte_t        fifo_read_data_o,
    output capture_pkg::error_status_t error_stat_o,
    output logic                      error_flag_o
);

    import capture_pkg::*;
    import readout_pkg::*;

    byte_slot_t    slot;
    byte_slot_t    slot_last;
    logic [3:0]    nib_r;      // low nibble of the first word of a pair
    byte_t         rd_byte;
    error_status_t err;

    assign slot_last = low_res_i ? 4'd2 : 4'd8;

    // pop once the last byte of a word has been taken
    assign pop_o = fifo_read_en_i &&
                   (low_res_i ? (slot == 4'd2) : ((slot == 4'd3) || (slot == 4'd8)));

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst) begin
            slot <= '0;
        end else if (fifo_read_en_i) begin
            slot <= (slot >= slot_last) ? '0 : slot + 1'b1;
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_read_en_i && !low_res_i && (slot == 4'd3)) begin
            nib_r <= head_i[3:0];
        end
    end

    always_comb begin
        rd_byte = '0;
        if (low_res_i) begin
            case (slot)
                4'd0:    rd_byte = head_i[35:28];    // top 8 of each sample
                4'd1:    rd_byte = head_i[23:16];
                4'd2:    rd_byte = head_i[11:4];
                default: rd_byte = '0;
            endcase
        end else begin
            case (slot)
                4'd0:    rd_byte = head_i[35:28];
                4'd1:    rd_byte = head_i[27:20];
                4'd2:    rd_byte = head_i[19:12];
                4'd3:    rd_byte = head_i[11:4];
                4'd4:    rd_byte = {nib_r, head_i[35:32]};    // spans both words
                4'd5:    rd_byte = head_i[31:24];
                4'd6:    rd_byte = head_i[23:16];
                4'd7:    rd_byte = head_i[15:8];
                4'd8:    rd_byte = head_i[7:0];
                default: rd_byte = '0;
            endcase
        end
    end

    // data is meaningless once a pop hit an empty FIFO
    assign fifo_read_data_o = err.underflow ? '0 : rd_byte;

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst || clear_errors_i) begin
            err <= '0;
        end else begin
            if (clip_i) begin
                err.clip <= 1'b1;
            end
            if (overflow_i) begin
                err.overflow <= 1'b1;
            end
            if (underflow_i && empty_i) begin
                err.underflow <= 1'b1;
            end
        end
    end

    assign error_stat_o = err;
    assign error_flag_o = |err;

endmodule

`default_nettype wire

/* rtl/adc_capture_top.sv */
`default_nettype none

`include "adc_capture_params.svh"

module adc_capture_top (
    input  wire logic                  adc_sampleclk,
    input  wire logic                  fifo_rst,
    input  wire logic                  arm_i,
    input  wire logic                  capture_go_i,
    input  wire capture_pkg::sample_t  adc_data_i,
    input  wire capture_pkg::count_t   downsample_i,
    input  wire capture_pkg::count_t   max_samples_i,
    input  wire logic                  low_res_i,
    input  wire logic                  fifo_read_en_i,
    input  wire logic                  clear_errors_i,
    output logic                       capture_stop_o,
    output logic                       fifo_empty_o,
    output readout_pkg::byte_t         fifo_read_data_o,
    output capture_pkg::error_status_t error_stat_o,
    output logic                       error_flag_o
);

    import capture_pkg::*;
    import readout_pkg::*;

    sample_beat_t beat;
    word_write_t  word_wr;
    word_t        head;
    logic         pop;
    logic         clip;
    logic         overflow;
    logic         underflow;

    capture_control u_capture_control (
        .adc_sampleclk  (adc_sampleclk),
        .fifo_rst       (fifo_rst),
        .arm_i          (arm_i),
        .capture_go_i   (capture_go_i),
        .adc_data_i     (adc_data_i),
        .downsample_i   (downsample_i),
        .max_samples_i  (max_samples_i),
        .beat_o         (beat),
        .clip_o         (clip),
        .capture_stop_o (capture_stop_o)
    );

    sample_packer u_sample_packer (
        .adc_sampleclk (adc_sampleclk),
        .fifo_rst      (fifo_rst),
        .beat_i        (beat),
        .wr_o          (word_wr)
    );

    word_fifo #(
        .DEPTH (`ADC_FIFO_DEPTH)
    ) u_word_fifo (
        .adc_sampleclk (adc_sampleclk),
        .fifo_rst      (fifo_rst),
        .wr_i          (word_wr),
        .pop_i         (pop),
        .head_o        (head),
        .empty_o       (fifo_empty_o),
        .overflow_o    (overflow),
        .underflow_o   (underflow)
    );

    byte_reader u_byte_reader (
        .adc_sampleclk    (adc_sampleclk),
        .fifo_rst         (fifo_rst),
        .fifo_read_en_i   (fifo_read_en_i),
        .low_res_i        (low_res_i),
        .clear_errors_i   (clear_errors_i),
        .head_i           (head),
        .empty_i          (fifo_empty_o),
        .clip_i           (clip),
        .overflow_i       (overflow),
        .underflow_i      (underflow),
        .pop_o            (pop),
        .fifo_read_data_o (fifo_read_data_o),
        .error_stat_o     (error_stat_o),
        .error_flag_o     (error_flag_o)
    );

endmodule

`default_nettype wire

/* verification/adc_capture_tb.sv */
`default_nettype none

`include "adc_capture_params.svh"

module adc_capture_tb;

    import capture_pkg::*;
    import readout_pkg::*;

    localparam int NUM_RUNS       = 12;
    localparam int TIMEOUT_CYCLES = (NUM_RUNS + 4) * (120 * 4 + 400);    // random runs plus directed

    localparam error_status_t NO_ERR    = '{clip: 1'b0, overflow: 1'b0, underflow: 1'b0};
    localparam error_status_t CLIP_ERR  = '{clip: 1'b1, overflow: 1'b0, underflow: 1'b0};
    localparam error_status_t OVER_ERR  = '{clip: 1'b0, overflow: 1'b1, underflow: 1'b0};
    localparam error_status_t UNDER_ERR = '{clip: 1'b0, overflow: 1'b0, underflow: 1'b1};

    logic          adc_sampleclk;
    logic          fifo_rst;
    logic          arm_i;
    logic          capture_go_i;
    sample_t       adc_data_i;
    count_t        downsample_i;
    count_t        max_samples_i;
    logic          low_res_i;
    logic          fifo_read_en_i;
    logic          clear_errors_i;
    logic          capture_stop_o;
    logic          fifo_empty_o;
    byte_t         fifo_read_data_o;
    error_status_t error_stat_o;
    logic          error_flag_o;

    integer  seed;
    int      cycle_cnt;
    int      count_errors;
    int      data_errors;
    int      status_errors;
    sample_t ramp_val;       // next value for the ADC input
    sample_t last_driven;
    bit      skip_codes;     // ramp avoids the rail codes
    byte_t   got_bytes[$];

    adc_capture_top UUT (
        .adc_sampleclk    (adc_sampleclk),
        .fifo_rst         (fifo_rst),
        .arm_i            (arm_i),
        .capture_go_i     (capture_go_i),
        .adc_data_i       (adc_data_i),
        .downsample_i     (downsample_i),
        .max_samples_i    (max_samples_i),
        .low_res_i        (low_res_i),
        .fifo_read_en_i   (fifo_read_en_i),
        .clear_errors_i   (clear_errors_i),
        .capture_stop_o   (capture_stop_o),
        .fifo_empty_o     (fifo_empty_o),
        .fifo_read_data_o (fifo_read_data_o),
        .error_stat_o     (error_stat_o),
        .error_flag_o     (error_flag_o)
    );

    initial begin
        adc_sampleclk = 1'b0;
        forever #10 adc_sampleclk = ~adc_sampleclk;
    end

    // ramp position n cycles ahead, 0 and 0xFFF left out when skipping
    function automatic sample_t ramp_advance(input sample_t v, input int n, input bit skip);
        int base;
        if (skip) begin
            base = (int'(v) - 1 + n) % 4094;
            return sample_t'(base + 1);
        end
        return sample_t'((int'(v) + n) % 4096);
    endfunction

    function automatic sample_t random_start();
        return sample_t'(($unsigned($random(seed)) % 4094) + 1);
    endfunction

    // one clock edge; the ramp moves on every cycle
    task automatic step_clock();
        @(posedge adc_sampleclk);
        adc_data_i  <= ramp_val;
        last_driven = ramp_val;
        ramp_val    = ramp_advance(ramp_val, 1, skip_codes);
    endtask

    task automatic clear_errors();
        step_clock();
        clear_errors_i <= 1'b1;
        step_clock();
        clear_errors_i <= 1'b0;
    endtask

    task automatic check_status(input error_status_t exp_err, input string what);
        @(negedge adc_sampleclk);
        if (error_stat_o !== exp_err || error_flag_o !== (|exp_err)) begin
            status_errors++;
            $display("Fail at %0t: %s, status %b flag %b, expected status %b", $time, what,
                     error_stat_o, error_flag_o, exp_err);
        end
    endtask

    // arm, go, then wait for the stop level and the last word
    task automatic capture_run(input int ds, input int max_s, input bit low_res,
                               output sample_t go_val);
        step_clock();
        downsample_i  <= count_t'(ds);
        max_samples_i <= count_t'(max_s);
        low_res_i     <= low_res;
        arm_i         <= 1'b1;
        step_clock();
        arm_i <= 1'b0;
        step_clock();
        step_clock();
        capture_go_i <= 1'b1;
        go_val = last_driven;        // kept sample k sits (k+1)*(ds+1) steps later
        step_clock();
        capture_go_i <= 1'b0;
        @(negedge adc_sampleclk);
        while (!capture_stop_o) begin
            step_clock();
            @(negedge adc_sampleclk);
        end
        repeat (3) step_clock();
    endtask

    // read while the FIFO is not empty, with random gaps
    task automatic read_all(input bit low_res);
        int idx;
        bit pop_byte;
        bit empty_s;
        idx = 0;
        @(negedge adc_sampleclk);
        empty_s = fifo_empty_o;
        while (!empty_s) begin
            step_clock();
            fifo_read_en_i <= 1'b1;
            @(negedge adc_sampleclk);
            got_bytes.push_back(fifo_read_data_o);
            pop_byte = low_res ? (idx % 3 == 2) : ((idx % 9 == 3) || (idx % 9 == 8));
            idx++;
            if (pop_byte || (($random(seed) & 3) == 0)) begin
                step_clock();             // idle cycle, empty is fresh after a pop
                fifo_read_en_i <= 1'b0;
                @(negedge adc_sampleclk);
            end
            empty_s = fifo_empty_o;
        end
    endtask

    // full res stream is plain 12-bit samples, msb first
    function automatic sample_t unpack_sample(input int k);
        int b;
        b = (k / 2) * 3;
        if (k % 2 == 0) begin
            return {got_bytes[b], got_bytes[b+1][7:4]};
        end
        return {got_bytes[b+1][3:0], got_bytes[b+2]};
    endfunction

    task automatic check_capture(input bit low_res, input int ds, input int n_exp,
                                 input sample_t go_val, input bit skip);
        int      exp_bytes;
        int      n_got;
        int      k;
        sample_t exp_s;
        sample_t got_s;
        exp_bytes = low_res ? n_exp : (n_exp * 3) / 2;
        n_got     = low_res ? got_bytes.size() : (got_bytes.size() * 2) / 3;
        if (got_bytes.size() != exp_bytes) begin
            count_errors++;
            $display("Fail at %0t: %0d bytes returned, expected %0d", $time,
                     got_bytes.size(), exp_bytes);
        end
        for (k = 0; k < n_got && k < n_exp; k++) begin
            exp_s = ramp_advance(go_val, (k + 1) * (ds + 1), skip);
            got_s = low_res ? {got_bytes[k], 4'h0} : unpack_sample(k);
            if ((low_res && got_s[11:4] != exp_s[11:4]) || (!low_res && got_s != exp_s)) begin
                data_errors++;
                $display("Fail at %0t: sample %0d got %h expected %h (low_res %0b)", $time,
                         k, got_s, exp_s, low_res);
            end
        end
        got_bytes.delete();
    endtask

    // hang guard
    always @(posedge adc_sampleclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Errors: %0d count, %0d data, %0d status",
                     count_errors, data_errors, status_errors);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        int      run;
        int      ds;
        int      max_s;
        int      n_exp;
        bit      low_res;
        sample_t go_val;
        seed           = 6725;
        cycle_cnt      = 0;
        count_errors   = 0;
        data_errors    = 0;
        status_errors  = 0;
        skip_codes     = 1'b1;
        ramp_val       = random_start();
        last_driven    = ramp_val;
        fifo_rst       = 1'b1;
        arm_i          = 1'b0;
        capture_go_i   = 1'b0;
        adc_data_i     = ramp_val;
        downsample_i   = '0;
        max_samples_i  = '0;
        low_res_i      = 1'b1;
        fifo_read_en_i = 1'b0;
        clear_errors_i = 1'b0;

        repeat (16) step_clock();
        fifo_rst <= 1'b0;
        step_clock();
        check_status(NO_ERR, "after reset");

        for (run = 0; run < NUM_RUNS; run++) begin
            ds      = $unsigned($random(seed)) % 4;
            max_s   = $unsigned($random(seed)) % 120 + 1;
            low_res = ($random(seed) & 1) != 0;
            n_exp   = ((max_s + 2) / 3) * 3;
            if (!low_res && ((n_exp / 3) % 2 == 1)) begin
                max_s += 3;              // full res reads words in pairs
                n_exp += 3;
            end
            capture_run(ds, max_s, low_res, go_val);
            read_all(low_res);
            check_capture(low_res, ds, n_exp, go_val, 1'b1);
            check_status(NO_ERR, "random capture");
        end

        // ramp through 0xFFF and 0x000
        skip_codes = 1'b0;
        ramp_val   = 12'hFF0;
        capture_run(0, 30, 1'b1, go_val);
        read_all(1'b1);
        check_capture(1'b1, 0, 30, go_val, 1'b0);
        check_status(CLIP_ERR, "ramp through full scale");
        clear_errors();
        check_status(NO_ERR, "clip cleared");
        skip_codes = 1'b1;
        ramp_val   = random_start();

        // one read cycle on an empty FIFO
        step_clock();
        low_res_i <= 1'b1;
        @(negedge adc_sampleclk);
        if (!fifo_empty_o) begin
            status_errors++;
            $display("FIFO still holds data before the empty read at %0t", $time);
        end
        repeat (3) begin
            step_clock();
            fifo_read_en_i <= 1'b1;
        end
        step_clock();
        fifo_read_en_i <= 1'b0;
        check_status(UNDER_ERR, "read from empty FIFO");
        repeat (3) begin
            @(negedge adc_sampleclk);
            if (fifo_read_data_o !== 8'h00) begin
                data_errors++;
                $display("Fail at %0t: read data %h after underflow, expected 00", $time,
                         fifo_read_data_o);
            end
        end
        clear_errors();
        check_status(NO_ERR, "underflow cleared");

        // 80 words into a 64-word FIFO
        capture_run(0, 120, 1'b1, go_val);
        capture_run(0, 120, 1'b1, go_val);
        check_status(OVER_ERR, "two captures without reads");
        read_all(1'b1);
        if (got_bytes.size() != `ADC_FIFO_DEPTH * 3) begin
            count_errors++;
            $display("Fail at %0t: %0d bytes after overflow, expected %0d", $time,
                     got_bytes.size(), `ADC_FIFO_DEPTH * 3);
        end
        got_bytes.delete();
        clear_errors();
        check_status(NO_ERR, "overflow cleared");

        $display("Errors: %0d count, %0d data, %0d status",
                 count_errors, data_errors, status_errors);
        if (count_errors + data_errors + status_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* adc_capture.f */
+incdir+rtl
rtl/capture_pkg.sv
rtl/readout_pkg.sv
rtl/capture_control.sv
rtl/sample_packer.sv
rtl/word_fifo.sv
rtl/byte_reader.sv
rtl/adc_capture_top.sv
verification/adc_capture_tb.sv

/* run_sim.sh */
#!/bin/sh
verilator --binary --timing --assert -f adc_capture.f --top-module adc_capture_tb \
    -o adc_capture_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/adc_capture_sim > sim.log 2>&1
grep -q "^Regression passed$" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
